//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = exec_stage_tb
FILELIST = exec_stage.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- exec_stage.f
hdl/exec_pkg.sv
hdl/instr_decode.sv
hdl/int_alu.sv
hdl/branch_unit.sv
hdl/exec_control.sv
hdl/exec_stage.sv
verification/exec_stage_sva.sv
verification/exec_stage_tb.sv

//--- hdl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  exec_pkg::decoded_t          decoded,
    input  logic [exec_pkg::ALEN-1:0]   pc,
    input  logic [exec_pkg::XLEN-1:0]   rs1_data,
    input  logic [exec_pkg::XLEN-1:0]   rs2_data,
    output exec_pkg::branch_res_t       br
);
    import exec_pkg::*;

    logic            is_unit;
    logic            is_jal;
    logic            is_jalr;
    logic            is_branch;
    logic [ALEN-1:0] add_a;
    logic [ALEN-1:0] sum;
    logic [ALEN-1:0] target;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            cond;
    logic            taken;
    logic            illegal;
    logic            misaligned;

    assign is_unit   = decoded.sel == SEL_BRANCH;
    assign is_jal    = is_unit && decoded.opcode == OP_JAL;
    assign is_jalr   = is_unit && decoded.opcode == OP_JALR;
    assign is_branch = is_unit && decoded.opcode == OP_BRANCH;

    // Single adder for all three target forms
    assign add_a  = is_jalr ? rs1_data : pc;
    assign sum    = add_a + decoded.imm;
    assign target = is_jalr ? {sum[ALEN-1:1], 1'b0} : sum;

    assign eq  = rs1_data == rs2_data;
    assign lt  = $signed(rs1_data) < $signed(rs2_data);
    assign ltu = rs1_data < rs2_data;

    always_comb begin
        case (decoded.funct3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt;
            F3_BGE:  cond = !lt;
            F3_BLTU: cond = ltu;
            F3_BGEU: cond = !ltu;
            default: cond = 1'b0; // 010 and 011 are reserved
        endcase
    end

    assign taken = is_jal || is_jalr || (is_branch && cond);

    always_comb begin
        illegal = decoded.illegal;
        if (is_jalr && decoded.funct3 != 3'b000) begin
            illegal = 1'b1;
        end
        if (is_branch && (decoded.funct3 == 3'b010 || decoded.funct3 == 3'b011)) begin
            illegal = 1'b1;
        end
    end

    // Only IALIGN 32, bit 0 is already clear on every target
    assign misaligned = taken && target[1];

    always_comb begin
        br.taken     = taken;
        br.target    = target;
        br.exception = illegal || misaligned;
        if (illegal) begin
            br.cause = EXC_ILLEGAL_INSTR;
        end else if (misaligned) begin
            br.cause = EXC_INSTR_ADDR_MISALIGNED;
        end else begin
            br.cause = '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_control.sv
`timescale 1ns/1ps
`default_nettype none

module exec_control (
    input  logic                        clk,
    input  logic                        rst,
    input  exec_pkg::exec_in_t          exec_in,
    input  exec_pkg::decoded_t          decoded,
    input  logic [exec_pkg::XLEN-1:0]   alu_result,
    input  exec_pkg::branch_res_t       br,
    output logic                        wb_valid,
    output exec_pkg::wb_t               wb,
    output exec_pkg::redirect_t         redirect
);
    import exec_pkg::*;

    logic            pending_taken;
    logic [ALEN-1:0] last_target;
    logic            mispredict;
    logic            accept;
    logic            is_branch;
    logic            writes_rd;
    wb_t             wb_next;

    // Fetch went down the fall-through path after a taken branch
    assign mispredict = exec_in.valid && pending_taken && exec_in.pc != last_target;
    assign accept     = exec_in.valid && !mispredict;
    assign is_branch  = decoded.sel == SEL_BRANCH;

    assign redirect.valid = mispredict;
    assign redirect.pc    = last_target;

    assign writes_rd = decoded.sel == SEL_ALU ||
                       (is_branch && decoded.opcode != OP_BRANCH); // JAL, JALR

    always_comb begin
        wb_next.rd        = decoded.rd;
        wb_next.we        = writes_rd && decoded.rd != 5'd0 && !br.exception;
        wb_next.wdata     = is_branch ? exec_in.next_pc : alu_result; // Link address
        wb_next.exception = br.exception;
        wb_next.cause     = br.cause;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_taken <= 1'b0;
        end else if (accept) begin
            pending_taken <= is_branch && br.taken && !br.exception;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_branch && br.taken) begin
            last_target <= br.target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb <= wb_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN = 32;
    localparam int ALEN = 32;

    // Major opcodes, instruction bits 6:2
    localparam logic [4:0] OP_LUI    = 5'b01101;
    localparam logic [4:0] OP_AUIPC  = 5'b00101;
    localparam logic [4:0] OP_JAL    = 5'b11011;
    localparam logic [4:0] OP_JALR   = 5'b11001;
    localparam logic [4:0] OP_BRANCH = 5'b11000;
    localparam logic [4:0] OP_IMM    = 5'b00100;
    localparam logic [4:0] OP_OP     = 5'b01100;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_ADD  = 3'b000; // ADD and SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

    localparam logic [3:0] EXC_INSTR_ADDR_MISALIGNED = 4'd0;
    localparam logic [3:0] EXC_ILLEGAL_INSTR         = 4'd2;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic        imm20;
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic            valid;
        logic [ALEN-1:0] pc;
        logic [ALEN-1:0] next_pc;
        instr_u          instr;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
    } exec_in_t;

    typedef enum logic [1:0] {
        SEL_ALU,
        SEL_BRANCH,
        SEL_NONE
    } unit_sel_e;

    typedef struct packed {
        unit_sel_e       sel;
        logic [4:0]      opcode;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic            funct7_5;
        logic [XLEN-1:0] imm;
        logic            illegal;
    } decoded_t;

    typedef struct packed {
        logic            taken;
        logic [ALEN-1:0] target;
        logic            exception;
        logic [3:0]      cause;
    } branch_res_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic            we;
        logic [XLEN-1:0] wdata;
        logic            exception;
        logic [3:0]      cause;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [ALEN-1:0] pc;
    } redirect_t;

endpackage

`default_nettype wire

//--- hdl/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  exec_pkg::exec_in_t    exec_in,
    output logic                  wb_valid,
    output exec_pkg::wb_t         wb,
    output exec_pkg::redirect_t   redirect
);
    import exec_pkg::*;

    decoded_t        decoded;
    logic [XLEN-1:0] alu_result;
    branch_res_t     br;

    instr_decode u_decode (
        .instr   (exec_in.instr),
        .decoded (decoded)
    );

    int_alu u_alu (
        .decoded  (decoded),
        .pc       (exec_in.pc),
        .rs1_data (exec_in.rs1_data),
        .rs2_data (exec_in.rs2_data),
        .result   (alu_result)
    );

    branch_unit u_branch (
        .decoded  (decoded),
        .pc       (exec_in.pc),
        .rs1_data (exec_in.rs1_data),
        .rs2_data (exec_in.rs2_data),
        .br       (br)
    );

    exec_control u_control (
        .clk        (clk),
        .rst        (rst),
        .exec_in    (exec_in),
        .decoded    (decoded),
        .alu_result (alu_result),
        .br         (br),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .redirect   (redirect)
    );

endmodule

`default_nettype wire

//--- hdl/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  exec_pkg::instr_u   instr,
    output exec_pkg::decoded_t decoded
);
    import exec_pkg::*;

    logic [4:0]      opc;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            shamt_bad;
    logic            op_bad;

    assign opc = instr.r_fmt.opcode[6:2];

    assign imm_i = {{(XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};

    // B immediate is scattered over the S layout
    assign imm_b = {{(XLEN-13){instr.s_fmt.imm_hi[6]}},
                    instr.s_fmt.imm_hi[6],
                    instr.s_fmt.imm_lo[0],
                    instr.s_fmt.imm_hi[5:0],
                    instr.s_fmt.imm_lo[4:1],
                    1'b0};

    assign imm_u = {instr.u_fmt.imm20, {(XLEN-20){1'b0}}};

    assign imm_j = {{(XLEN-21){instr.j_fmt.imm20}},
                    instr.j_fmt.imm20,
                    instr.j_fmt.imm19_12,
                    instr.j_fmt.imm11,
                    instr.j_fmt.imm10_1,
                    1'b0};

    // Upper immediate bits of SLLI, SRLI and SRAI
    always_comb begin
        shamt_bad = 1'b0;
        if (instr.r_fmt.funct3 == F3_SLL) begin
            shamt_bad = instr.r_fmt.funct7 != F7_BASE;
        end else if (instr.r_fmt.funct3 == F3_SR) begin
            shamt_bad = instr.r_fmt.funct7 != F7_BASE && instr.r_fmt.funct7 != F7_ALT;
        end
    end

    always_comb begin
        if (instr.r_fmt.funct7 == F7_BASE) begin
            op_bad = 1'b0;
        end else if (instr.r_fmt.funct7 == F7_ALT) begin
            op_bad = !(instr.r_fmt.funct3 == F3_ADD || instr.r_fmt.funct3 == F3_SR);
        end else begin
            op_bad = 1'b1;
        end
    end

    always_comb begin
        decoded.sel      = SEL_NONE;
        decoded.opcode   = opc;
        decoded.rd       = instr.r_fmt.rd;
        decoded.funct3   = instr.r_fmt.funct3;
        decoded.funct7_5 = instr.r_fmt.funct7[5];
        decoded.imm      = '0;
        decoded.illegal  = instr.r_fmt.opcode[1:0] != 2'b11; // No compressed forms
        case (opc)
            OP_LUI, OP_AUIPC: begin
                decoded.sel = SEL_ALU;
                decoded.imm = imm_u;
            end
            OP_IMM: begin
                decoded.sel     = SEL_ALU;
                decoded.imm     = imm_i;
                decoded.illegal = decoded.illegal | shamt_bad;
            end
            OP_OP: begin
                decoded.sel     = SEL_ALU;
                decoded.illegal = decoded.illegal | op_bad;
            end
            OP_JAL: begin
                decoded.sel = SEL_BRANCH;
                decoded.imm = imm_j;
            end
            OP_JALR: begin
                decoded.sel = SEL_BRANCH;
                decoded.imm = imm_i;
            end
            OP_BRANCH: begin
                decoded.sel = SEL_BRANCH;
                decoded.imm = imm_b;
                decoded.rd  = '0; // Field holds immediate bits
            end
            default: begin
                decoded.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  exec_pkg::decoded_t          decoded,
    input  logic [exec_pkg::ALEN-1:0]   pc,
    input  logic [exec_pkg::XLEN-1:0]   rs1_data,
    input  logic [exec_pkg::XLEN-1:0]   rs2_data,
    output logic [exec_pkg::XLEN-1:0]   result
);
    import exec_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            is_sub;
    logic            lt;
    logic            ltu;

    assign op_b   = (decoded.opcode == OP_OP) ? rs2_data : decoded.imm;
    assign shamt  = op_b[4:0];
    assign is_sub = decoded.opcode == OP_OP && decoded.funct7_5; // No SUBI
    assign lt     = $signed(rs1_data) < $signed(op_b);
    assign ltu    = rs1_data < op_b;

    always_comb begin
        result = '0;
        case (decoded.opcode)
            OP_LUI: begin
                result = decoded.imm;
            end
            OP_AUIPC: begin
                result = pc + decoded.imm;
            end
            OP_OP, OP_IMM: begin
                case (decoded.funct3)
                    F3_ADD:  result = is_sub ? rs1_data - op_b : rs1_data + op_b;
                    F3_SLL:  result = rs1_data << shamt;
                    F3_SLT:  result = {{(XLEN-1){1'b0}}, lt};
                    F3_SLTU: result = {{(XLEN-1){1'b0}}, ltu};
                    F3_XOR:  result = rs1_data ^ op_b;
                    F3_SR: begin
                        if (decoded.funct7_5) begin
                            result = $unsigned($signed(rs1_data) >>> shamt);
                        end else begin
                            result = rs1_data >> shamt;
                        end
                    end
                    F3_OR:   result = rs1_data | op_b;
                    default: result = rs1_data & op_b; // AND
                endcase
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verification/exec_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_sva (
    input logic                clk,
    input logic                rst,
    input exec_pkg::exec_in_t  exec_in,
    input logic                mispredict,
    input logic                pending_taken,
    input logic                wb_valid,
    input exec_pkg::wb_t       wb,
    input exec_pkg::redirect_t redirect
);

    a_reset_idle: assert property (@(posedge clk) rst |=> !wb_valid)
        else $error("wb_valid high in the cycle after reset");

    // One cycle from accept to writeback
    a_wb_follows: assert property (@(posedge clk) disable iff (rst)
        (exec_in.valid && !mispredict) |=> wb_valid)
        else $error("accepted instruction produced no writeback");

    a_no_extra_wb: assert property (@(posedge clk) disable iff (rst)
        !(exec_in.valid && !mispredict) |=> !wb_valid)
        else $error("writeback without an accepted instruction");

    a_redirect_pending: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> pending_taken)
        else $error("redirect raised with no taken branch pending");

    a_exc_no_write: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && wb.exception) |-> !wb.we)
        else $error("write enable set on an excepting instruction");

endmodule

bind exec_control exec_stage_sva u_sva (
    .clk           (clk),
    .rst           (rst),
    .exec_in       (exec_in),
    .mispredict    (mispredict),
    .pending_taken (pending_taken),
    .wb_valid      (wb_valid),
    .wb            (wb),
    .redirect      (redirect)
);

`default_nettype wire

//--- verification/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb;
    import exec_pkg::*;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        exp_wb_valid;
        logic [4:0]  exp_rd;
        logic        exp_we;
        logic [31:0] exp_wdata;
        logic        exp_exc;
        logic [3:0]  exp_cause;
        logic        exp_redirect;
        logic [31:0] exp_redirect_pc;
    } row_t;

    logic        clk;
    logic        rst;
    exec_in_t    exec_in;
    logic        wb_valid;
    wb_t         wb;
    redirect_t   redirect;

    row_t        rows[$];
    int          fails[];
    int          seed;
    int          errors;
    int          passed;
    logic [31:0] cur_pc;
    logic        table_ready;

    exec_stage UUT (
        .clk      (clk),
        .rst      (rst),
        .exec_in  (exec_in),
        .wb_valid (wb_valid),
        .wb       (wb),
        .redirect (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Instruction encoders with fixed source register fields
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] opc);
        return {f7, 5'd2, 5'd1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] opc);
        return {imm, 5'd1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OP_BRANCH, 2'b11};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL, 2'b11};
    endfunction

    // ISA result of an OP, OP-IMM, LUI or AUIPC word
    function automatic logic [31:0] alu_ref(input logic [31:0] instr, input logic [31:0] pc,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] opb;
        logic [4:0]  sh;
        opb = (instr[6:2] == OP_OP) ? b : {{20{instr[31]}}, instr[31:20]};
        sh  = opb[4:0];
        case (instr[6:2])
            OP_LUI:   return {instr[31:12], 12'h000};
            OP_AUIPC: return pc + {instr[31:12], 12'h000};
            default: begin
                case (instr[14:12])
                    3'd0:    return (instr[6:2] == OP_OP && instr[30]) ? a - opb : a + opb;
                    3'd1:    return a << sh;
                    3'd2:    return ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
                    3'd3:    return (a < opb) ? 32'd1 : 32'd0;
                    3'd4:    return a ^ opb;
                    3'd5:    return instr[30] ? 32'($signed(a) >>> sh) : a >> sh;
                    3'd6:    return a | opb;
                    default: return a & opb;
                endcase
            end
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic idle_row();
        row_t r;
        r = '0;
        rows.push_back(r);
    endtask

    task automatic alu_row(input logic [4:0] opc, input logic [2:0] f3,
                           input logic [6:0] f7, input logic [4:0] rd);
        row_t        r;
        logic [31:0] rnd;
        r         = '0;
        r.valid   = 1'b1;
        r.pc      = cur_pc;
        r.next_pc = cur_pc + 32'd4;
        r.rs1     = $random(seed);
        r.rs2     = $random(seed);
        rnd       = $random(seed);
        if (opc == OP_OP) begin
            r.instr = r_word(f7, f3, rd, opc);
        end else if (opc == OP_LUI || opc == OP_AUIPC) begin
            r.instr = {rnd[31:12], rd, opc, 2'b11};
        end else if (f3 == F3_SLL || f3 == F3_SR) begin
            r.instr = i_word({f7, rnd[4:0]}, f3, rd, opc); // Shift amount
        end else begin
            r.instr = i_word(rnd[11:0], f3, rd, opc);
        end
        r.exp_wb_valid = 1'b1;
        r.exp_rd       = rd;
        r.exp_we       = rd != 5'd0;
        r.exp_wdata    = alu_ref(r.instr, r.pc, r.rs1, r.rs2);
        rows.push_back(r);
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic branch_row(input logic [2:0] f3, input logic [31:0] a,
                              input logic [31:0] b);
        row_t r;
        logic bad;
        logic taken;
        r              = '0;
        bad            = f3 == 3'b010 || f3 == 3'b011;
        taken          = !bad && branch_ref(f3, a, b);
        r.valid        = 1'b1;
        r.pc           = cur_pc;
        r.next_pc      = cur_pc + 32'd4;
        r.instr        = b_word(13'd16, f3);
        r.rs1          = a;
        r.rs2          = b;
        r.exp_wb_valid = 1'b1;
        r.exp_exc      = bad;
        r.exp_cause    = bad ? EXC_ILLEGAL_INSTR : 4'd0;
        rows.push_back(r);
        cur_pc = taken ? cur_pc + 32'd16 : cur_pc + 32'd4;
    endtask

    task automatic squashed_row(input logic [31:0] pc, input logic [31:0] target);
        row_t r;
        r                 = '0;
        r.valid           = 1'b1;
        r.pc              = pc;
        r.next_pc         = pc + 32'd4;
        r.instr           = i_word(12'h001, F3_ADD, 5'd9, OP_IMM);
        r.rs1             = $random(seed);
        r.exp_redirect    = 1'b1;
        r.exp_redirect_pc = target;
        rows.push_back(r);
    endtask

    // Taken case, a squashed fall-through, its target, then the not-taken case
    task automatic branch_cases(input logic [2:0] f3, input logic [31:0] at, input logic [31:0] bt,
                                input logic [31:0] an, input logic [31:0] bn);
        logic [31:0] branch_pc;
        branch_pc = cur_pc;
        branch_row(f3, at, bt);
        squashed_row(branch_pc + 32'd4, cur_pc);
        alu_row(OP_IMM, F3_ADD, F7_BASE, 5'd7);
        branch_row(f3, an, bn);
        alu_row(OP_IMM, F3_XOR, F7_BASE, 5'd8);
    endtask

    task automatic jal_row(input logic [20:0] off, input logic [4:0] rd);
        row_t        r;
        logic [31:0] target;
        logic        mis;
        r              = '0;
        target         = cur_pc + {{11{off[20]}}, off};
        mis            = target[1];
        r.valid        = 1'b1;
        r.pc           = cur_pc;
        r.next_pc      = cur_pc + 32'd4;
        r.instr        = j_word(off, rd);
        r.exp_wb_valid = 1'b1;
        r.exp_rd       = rd;
        r.exp_we       = !mis && rd != 5'd0;
        r.exp_wdata    = r.next_pc;
        r.exp_exc      = mis;
        r.exp_cause    = EXC_INSTR_ADDR_MISALIGNED;
        rows.push_back(r);
        cur_pc = mis ? cur_pc + 32'd4 : target;
    endtask

    task automatic jalr_row(input logic [2:0] f3, input logic [31:0] base,
                            input logic [11:0] imm, input logic [4:0] rd);
        row_t        r;
        logic [31:0] target;
        logic        bad;
        logic        exc;
        r              = '0;
        target         = (base + {{20{imm[11]}}, imm}) & 32'hffff_fffe;
        bad            = f3 != 3'b000;
        exc            = bad || target[1];
        r.valid        = 1'b1;
        r.pc           = cur_pc;
        r.next_pc      = cur_pc + 32'd4;
        r.instr        = i_word(imm, f3, rd, OP_JALR);
        r.rs1          = base;
        r.exp_wb_valid = 1'b1;
        r.exp_rd       = rd;
        r.exp_we       = !exc && rd != 5'd0;
        r.exp_wdata    = r.next_pc;
        r.exp_exc      = exc;
        r.exp_cause    = bad ? EXC_ILLEGAL_INSTR : EXC_INSTR_ADDR_MISALIGNED;
        rows.push_back(r);
        cur_pc = exc ? cur_pc + 32'd4 : target;
    endtask

    task automatic illegal_row(input logic [31:0] instr);
        row_t r;
        r              = '0;
        r.valid        = 1'b1;
        r.pc           = cur_pc;
        r.next_pc      = cur_pc + 32'd4;
        r.instr        = instr;
        r.exp_wb_valid = 1'b1;
        r.exp_rd       = instr[11:7];
        r.exp_exc      = 1'b1;
        r.exp_cause    = EXC_ILLEGAL_INSTR;
        rows.push_back(r);
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic build_table();
        logic [31:0] branch_pc;
        cur_pc = 32'h0000_0100;
        idle_row();
        idle_row();
        for (int k = 0; k < 8; k++) alu_row(OP_OP, 3'(k), F7_BASE, 5'(k + 1));
        alu_row(OP_OP, F3_ADD, F7_ALT, 5'd10); // SUB
        alu_row(OP_OP, F3_SR, F7_ALT, 5'd11);  // SRA
        for (int k = 0; k < 8; k++) alu_row(OP_IMM, 3'(k), F7_BASE, 5'(k + 12));
        alu_row(OP_IMM, F3_SR, F7_ALT, 5'd20); // SRAI
        alu_row(OP_LUI, 3'd0, F7_BASE, 5'd21);
        alu_row(OP_AUIPC, 3'd0, F7_BASE, 5'd22);
        alu_row(OP_OP, F3_ADD, F7_BASE, 5'd0);
        alu_row(OP_IMM, F3_OR, F7_BASE, 5'd0);
        branch_cases(F3_BEQ, 32'd7, 32'd7, 32'd7, 32'd8);
        branch_cases(F3_BNE, 32'd7, 32'd8, 32'd7, 32'd7);
        branch_cases(F3_BLT, -32'sd5, 32'd3, 32'd3, -32'sd5);
        branch_cases(F3_BGE, 32'd3, -32'sd5, -32'sd5, 32'd3);
        branch_cases(F3_BLTU, 32'd3, -32'sd5, -32'sd5, 32'd3);
        branch_cases(F3_BGEU, -32'sd5, 32'd3, 32'd3, -32'sd5);
        branch_pc = cur_pc;
        jal_row(21'd32, 5'd1);
        squashed_row(branch_pc + 32'd4, cur_pc);
        alu_row(OP_IMM, F3_ADD, F7_BASE, 5'd7);
        branch_pc = cur_pc;
        jalr_row(3'b000, 32'h0000_1001, 12'h010, 5'd2); // Odd sum has bit 0 dropped
        squashed_row(branch_pc + 32'd4, cur_pc);
        alu_row(OP_IMM, F3_ADD, F7_BASE, 5'd7);
        // Fetch keeps going down the fall-through path
        branch_pc = cur_pc;
        branch_row(F3_BNE, 32'd1, 32'd2);
        squashed_row(branch_pc + 32'd4, cur_pc);
        squashed_row(branch_pc + 32'd8, cur_pc);
        idle_row();
        alu_row(OP_IMM, F3_ADD, F7_BASE, 5'd7);
        jalr_row(3'b001, 32'h0000_2000, 12'h004, 5'd5);
        branch_row(3'b010, 32'd1, 32'd1);
        jal_row(21'd6, 5'd3);
        illegal_row({20'h00000, 5'd4, 5'b00010, 2'b11}); // Custom-0 opcode
        illegal_row(r_word(7'b0000001, F3_ADD, 5'd6, OP_OP)); // MUL
        idle_row();
        idle_row();
    endtask

    task automatic drive_row(input row_t r);
        exec_in.valid    <= r.valid;
        exec_in.pc       <= r.pc;
        exec_in.next_pc  <= r.next_pc;
        exec_in.instr    <= r.instr;
        exec_in.rs1_data <= r.rs1;
        exec_in.rs2_data <= r.rs2;
    endtask

    task automatic compare_field(input int idx, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] row %0d %s: got %h expected %h", idx, name, got, exp);
            fails[idx]++;
            errors++;
        end
    endtask

    task automatic redirect_check(input int idx);
        compare_field(idx, "redirect.valid", 32'(redirect.valid), 32'(rows[idx].exp_redirect));
        if (rows[idx].exp_redirect) begin
            compare_field(idx, "redirect.pc", redirect.pc, rows[idx].exp_redirect_pc);
        end
    endtask

    task automatic writeback_check(input int idx);
        row_t r;
        r = rows[idx];
        compare_field(idx, "wb_valid", 32'(wb_valid), 32'(r.exp_wb_valid));
        if (r.exp_wb_valid) begin
            compare_field(idx, "wb.rd", 32'(wb.rd), 32'(r.exp_rd));
            compare_field(idx, "wb.we", 32'(wb.we), 32'(r.exp_we));
            compare_field(idx, "wb.exception", 32'(wb.exception), 32'(r.exp_exc));
            compare_field(idx, "wb.cause", 32'(wb.cause), 32'(r.exp_cause));
            if (r.exp_we) begin
                compare_field(idx, "wb.wdata", wb.wdata, r.exp_wdata);
            end
        end
    endtask

    task automatic report_row(input int idx);
        if (fails[idx] == 0) begin
            passed++;
            $display("row %0d pc %h instr %h: ok", idx, rows[idx].pc, rows[idx].instr);
        end else begin
            $display("row %0d pc %h instr %h: %0d check(s) failed",
                     idx, rows[idx].pc, rows[idx].instr, fails[idx]);
        end
    endtask

    initial begin
        wait (table_ready);
        #((rows.size() + 10) * 40);
        $display("Watchdog timeout: the table did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        seed          = 87228;
        errors        = 0;
        passed        = 0;
        table_ready   = 1'b0;
        rst           <= 1'b1;
        exec_in       <= '0;
        exec_in.valid <= 1'b1; // Valid input held during reset
        build_table();
        fails       = new[rows.size()];
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (wb_valid === 1'b0) else begin
            $display("[ERROR] reset: wb_valid got %h expected 0", wb_valid);
            errors++;
        end
        @(posedge clk);
        rst           <= 1'b0;
        exec_in.valid <= 1'b0;
        // Redirect of row i and writeback of row i-1 share a cycle
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            drive_row(rows[i]);
            @(negedge clk);
            redirect_check(i);
            if (i > 0) begin
                writeback_check(i - 1);
                report_row(i - 1);
            end
        end
        @(posedge clk);
        exec_in.valid <= 1'b0;
        @(negedge clk);
        writeback_check(rows.size() - 1);
        report_row(rows.size() - 1);
        $display("rows %0d, passed %0d, failed %0d, failed checks %0d",
                 rows.size(), passed, rows.size() - passed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
